// ==== hw/glb_pkg.sv ====
`default_nettype none

package glb_pkg;

    localparam int GLB_ADDR_W = 32;
    localparam int GLB_DATA_W = 32;
    localparam int GLB_WEB_W  = 4;
    localparam int GLB_HALF_W = GLB_DATA_W / 2;   // one lane of the data word

    typedef logic [GLB_ADDR_W-1:0] glb_addr_t;
    typedef logic [GLB_DATA_W-1:0] glb_data_t;
    typedef logic [GLB_WEB_W-1:0]  glb_web_t;
    typedef logic [GLB_HALF_W-1:0] glb_half_t;

    // byte-enable codes understood by the GLB
    localparam glb_web_t WEB_LO_HALF = 4'b0011;   // low half-word only
    localparam glb_web_t WEB_HI_HALF = 4'b1100;   // high half-word only
    localparam glb_web_t WEB_FULL    = 4'b1111;   // both halves

    typedef struct packed {
        glb_half_t hi;
        glb_half_t lo;
    } glb_lanes_t;

    // same 32 bits, seen as a flat word or as two lanes
    typedef union packed {
        glb_data_t  word;
        glb_lanes_t lanes;
    } glb_word_u;

    // registered write command on the shared port
    typedef struct packed {
        logic      write;
        glb_addr_t addr;
        glb_web_t  web;
    } glb_cmd_t;

endpackage

`default_nettype wire

// ==== hw/pe_array_pkg.sv ====
`default_nettype none

package pe_array_pkg;

    localparam int PE_COLS = 32;   // columns in the PE array

    // opsum write target of one column
    typedef struct packed {
        glb_pkg::glb_addr_t addr;
        glb_pkg::glb_web_t  web;
    } pe_wr_req_t;

    // read target, shared by ifmap and ipsum
    typedef struct packed {
        glb_pkg::glb_addr_t addr;
    } pe_rd_req_t;

endpackage

`default_nettype wire

// ==== hw/req_priority_picker.sv ====
`timescale 1ns/100ps
`default_nettype none

module req_priority_picker #(
    parameter int NUM_PE = pe_array_pkg::PE_COLS,
    parameter int IDX_W  = (NUM_PE > 1) ? $clog2(NUM_PE) : 1
) (
    input  logic [NUM_PE-1:0] req_i,
    output logic [NUM_PE-1:0] grant_o,
    output logic [IDX_W-1:0]  idx_o,
    output logic              any_o
);

    // isolate lowest set bit, zero when idle
    assign grant_o = req_i & (~req_i + 1'b1);

    assign any_o = |req_i;

    // scan from the top down so the lowest hit is written last
    always_comb begin
        idx_o = '0;
        for (int i = NUM_PE - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                idx_o = IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/opsum_write_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module opsum_write_arbiter #(
    parameter int NUM_PE = pe_array_pkg::PE_COLS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [NUM_PE-1:0]         req_i,
    input  pe_array_pkg::pe_wr_req_t  wr_req_i   [NUM_PE],
    input  glb_pkg::glb_data_t        pop_data_i [NUM_PE],
    output logic [NUM_PE-1:0]         permit_o,
    output logic                      write_pending_o,
    output glb_pkg::glb_cmd_t         cmd_o,
    output glb_pkg::glb_data_t        wdata_o
);

    import glb_pkg::*;

    localparam int IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    logic [IDX_W-1:0]  live_idx;
    logic              live_any;
    logic [NUM_PE-1:0] req_buf;   // requests seen last cycle
    logic [IDX_W-1:0]  buf_idx;
    logic              buf_any;
    glb_cmd_t          cmd_d;

    // live requests, permit goes out this cycle
    req_priority_picker #(
        .NUM_PE (NUM_PE),
        .IDX_W  (IDX_W)
    ) u_live_pick (
        .req_i   (req_i),
        .grant_o (permit_o),
        .idx_o   (live_idx),
        .any_o   (live_any)
    );

    // same pick one cycle late, finds the column that popped
    req_priority_picker #(
        .NUM_PE (NUM_PE),
        .IDX_W  (IDX_W)
    ) u_buf_pick (
        .req_i   (req_buf),
        .grant_o (),
        .idx_o   (buf_idx),
        .any_o   (buf_any)
    );

    assign write_pending_o = live_any;

    always_comb begin
        cmd_d = '0;
        if (live_any) begin
            cmd_d.write = 1'b1;
            cmd_d.addr  = wr_req_i[live_idx].addr;
            cmd_d.web   = wr_req_i[live_idx].web;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_buf <= '0;
            cmd_o   <= '0;
        end else begin
            req_buf <= req_i;
            cmd_o   <= cmd_d;   // idle cycle clears the command
        end
    end

    // fifo output of the column granted last cycle
    assign wdata_o = buf_any ? pop_data_i[buf_idx] : '0;

endmodule

`default_nettype wire

// ==== hw/glb_read_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module glb_read_arbiter #(
    parameter int NUM_PE = pe_array_pkg::PE_COLS
) (
    input  logic                      weight_load_i,
    input  glb_pkg::glb_addr_t        weight_addr_i,
    input  logic                      write_pending_i,
    input  logic                      write_active_i,
    input  logic [NUM_PE-1:0]         ifmap_req_i,
    input  logic [NUM_PE-1:0]         ipsum_req_i,
    input  pe_array_pkg::pe_rd_req_t  ifmap_addr_i [NUM_PE],
    input  pe_array_pkg::pe_rd_req_t  ipsum_addr_i [NUM_PE],
    output logic [NUM_PE-1:0]         permit_ifmap_o,
    output logic [NUM_PE-1:0]         permit_ipsum_o,
    output logic                      read_o,
    output glb_pkg::glb_addr_t        read_addr_o
);

    localparam int IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    logic [NUM_PE-1:0] ifmap_grant;
    logic [IDX_W-1:0]  ifmap_idx;
    logic              ifmap_any;
    logic [NUM_PE-1:0] ipsum_grant;
    logic [IDX_W-1:0]  ipsum_idx;
    logic              ipsum_any;
    logic              port_free;

    req_priority_picker #(
        .NUM_PE (NUM_PE),
        .IDX_W  (IDX_W)
    ) u_ifmap_pick (
        .req_i   (ifmap_req_i),
        .grant_o (ifmap_grant),
        .idx_o   (ifmap_idx),
        .any_o   (ifmap_any)
    );

    req_priority_picker #(
        .NUM_PE (NUM_PE),
        .IDX_W  (IDX_W)
    ) u_ipsum_pick (
        .req_i   (ipsum_req_i),
        .grant_o (ipsum_grant),
        .idx_o   (ipsum_idx),
        .any_o   (ipsum_any)
    );

    // opsum drain has the port this cycle or the next
    assign port_free = !write_pending_i && !write_active_i;

    always_comb begin
        permit_ifmap_o = '0;
        permit_ipsum_o = '0;
        read_o         = 1'b0;
        read_addr_o    = '0;
        if (weight_load_i) begin
            read_o      = 1'b1;   // weights ignore the write path
            read_addr_o = weight_addr_i;
        end else if (port_free) begin
            if (ifmap_any) begin
                permit_ifmap_o = ifmap_grant;
                read_o         = 1'b1;
                read_addr_o    = ifmap_addr_i[ifmap_idx].addr;
            end else if (ipsum_any) begin
                permit_ipsum_o = ipsum_grant;
                read_o         = 1'b1;
                read_addr_o    = ipsum_addr_i[ipsum_idx].addr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/glb_port_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module glb_port_mux (
    input  glb_pkg::glb_cmd_t  cmd_i,
    input  glb_pkg::glb_data_t wdata_i,
    input  logic               read_i,
    input  glb_pkg::glb_addr_t read_addr_i,
    output logic               glb_write_o,
    output glb_pkg::glb_addr_t glb_addr_o,
    output glb_pkg::glb_web_t  glb_write_web_o,
    output glb_pkg::glb_data_t glb_write_data_o
);

    import glb_pkg::*;

    glb_word_u src_w;   // unsteered word from the fifo
    glb_word_u dst_w;   // word as it goes onto the bus

    assign glb_write_o     = cmd_i.write;
    assign glb_write_web_o = cmd_i.web;

    // write owns the address when both are up
    always_comb begin
        if (cmd_i.write) begin
            glb_addr_o = cmd_i.addr;
        end else if (read_i) begin
            glb_addr_o = read_addr_i;
        end else begin
            glb_addr_o = '0;
        end
    end

    assign src_w.word = wdata_i;

    // psum sits in the low half of the source, moved to the lane the mask opens
    always_comb begin
        dst_w.word = '0;
        case (cmd_i.web)
            WEB_LO_HALF: dst_w.lanes.lo = src_w.lanes.lo;
            WEB_HI_HALF: dst_w.lanes.hi = src_w.lanes.lo;
            WEB_FULL:    dst_w.word     = src_w.word;
            default:     dst_w.word     = '0;   // unknown mask drives nothing
        endcase
    end

    assign glb_write_data_o = dst_w.word;

endmodule

`default_nettype wire

// ==== hw/token_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module token_arbiter #(
    parameter int NUM_PE = pe_array_pkg::PE_COLS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      weight_load_state_i,
    input  glb_pkg::glb_addr_t        weight_addr_i,
    input  logic [NUM_PE-1:0]         opsum_write_req_i,
    input  logic [NUM_PE-1:0]         ifmap_read_req_i,
    input  logic [NUM_PE-1:0]         ipsum_read_req_i,
    input  pe_array_pkg::pe_wr_req_t  opsum_wr_req_i   [NUM_PE],
    input  pe_array_pkg::pe_rd_req_t  ifmap_rd_req_i   [NUM_PE],
    input  pe_array_pkg::pe_rd_req_t  ipsum_rd_req_i   [NUM_PE],
    input  glb_pkg::glb_data_t        opsum_pop_data_i [NUM_PE],
    output logic                      glb_read_o,
    output glb_pkg::glb_addr_t        glb_addr_o,
    output logic                      glb_write_o,
    output glb_pkg::glb_web_t         glb_write_web_o,
    output glb_pkg::glb_data_t        glb_write_data_o,
    output logic [NUM_PE-1:0]         permit_ifmap_o,
    output logic [NUM_PE-1:0]         permit_ipsum_o,
    output logic [NUM_PE-1:0]         permit_opsum_o
);

    import glb_pkg::*;

    logic      write_pending;   // some column wants to drain
    glb_cmd_t  wr_cmd;
    glb_data_t wr_data;
    glb_addr_t rd_addr;

    opsum_write_arbiter #(
        .NUM_PE (NUM_PE)
    ) u_wr_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (opsum_write_req_i),
        .wr_req_i        (opsum_wr_req_i),
        .pop_data_i      (opsum_pop_data_i),
        .permit_o        (permit_opsum_o),
        .write_pending_o (write_pending),
        .cmd_o           (wr_cmd),
        .wdata_o         (wr_data)
    );

    glb_read_arbiter #(
        .NUM_PE (NUM_PE)
    ) u_rd_arb (
        .weight_load_i   (weight_load_state_i),
        .weight_addr_i   (weight_addr_i),
        .write_pending_i (write_pending),
        .write_active_i  (wr_cmd.write),   // write issued this cycle
        .ifmap_req_i     (ifmap_read_req_i),
        .ipsum_req_i     (ipsum_read_req_i),
        .ifmap_addr_i    (ifmap_rd_req_i),
        .ipsum_addr_i    (ipsum_rd_req_i),
        .permit_ifmap_o  (permit_ifmap_o),
        .permit_ipsum_o  (permit_ipsum_o),
        .read_o          (glb_read_o),
        .read_addr_o     (rd_addr)
    );

    glb_port_mux u_port_mux (
        .cmd_i            (wr_cmd),
        .wdata_i          (wr_data),
        .read_i           (glb_read_o),
        .read_addr_i      (rd_addr),
        .glb_write_o      (glb_write_o),
        .glb_addr_o       (glb_addr_o),
        .glb_write_web_o  (glb_write_web_o),
        .glb_write_data_o (glb_write_data_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);   // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_token_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_token_arbiter;

    import glb_pkg::*;
    import pe_array_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 3;
    localparam int SETTLE     = 10;   // ns after the falling edge
    // cycle budget of each test with a little slack
    localparam int CYC_RESET   = 2;
    localparam int CYC_WR_PRIO = 5;
    localparam int CYC_LANES   = 10;
    localparam int CYC_RD_PRIO = 5;
    localparam int CYC_BLOCK   = 5;
    localparam int CYC_WEIGHT  = 5;
    localparam int TOTAL_CYCLES = RST_CYCLES + CYC_RESET + CYC_WR_PRIO + CYC_LANES
                                + CYC_RD_PRIO + CYC_BLOCK + CYC_WEIGHT;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD + 800;

    logic               clk;
    logic               rst_n;
    logic               weight_load_state;
    glb_addr_t          weight_addr;
    logic [PE_COLS-1:0] opsum_write_req;
    logic [PE_COLS-1:0] ifmap_read_req;
    logic [PE_COLS-1:0] ipsum_read_req;
    pe_wr_req_t         opsum_wr_req   [PE_COLS];
    pe_rd_req_t         ifmap_rd_req   [PE_COLS];
    pe_rd_req_t         ipsum_rd_req   [PE_COLS];
    glb_data_t          opsum_pop_data [PE_COLS];
    logic               glb_read;
    glb_addr_t          glb_addr;
    logic               glb_write;
    glb_web_t           glb_write_web;
    glb_data_t          glb_write_data;
    logic [PE_COLS-1:0] permit_ifmap;
    logic [PE_COLS-1:0] permit_ipsum;
    logic [PE_COLS-1:0] permit_opsum;

    integer seed;
    int     err_cnt;
    int     tests_run;

    tb_clk_gen #(
        .PERIOD_NS  (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    token_arbiter #(
        .NUM_PE (PE_COLS)
    ) u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .weight_load_state_i (weight_load_state),
        .weight_addr_i       (weight_addr),
        .opsum_write_req_i   (opsum_write_req),
        .ifmap_read_req_i    (ifmap_read_req),
        .ipsum_read_req_i    (ipsum_read_req),
        .opsum_wr_req_i      (opsum_wr_req),
        .ifmap_rd_req_i      (ifmap_rd_req),
        .ipsum_rd_req_i      (ipsum_rd_req),
        .opsum_pop_data_i    (opsum_pop_data),
        .glb_read_o          (glb_read),
        .glb_addr_o          (glb_addr),
        .glb_write_o         (glb_write),
        .glb_write_web_o     (glb_write_web),
        .glb_write_data_o    (glb_write_data),
        .permit_ifmap_o      (permit_ifmap),
        .permit_ipsum_o      (permit_ipsum),
        .permit_opsum_o      (permit_opsum)
    );

    function automatic logic [PE_COLS-1:0] onehot(input int col);
        logic [PE_COLS-1:0] v;
        v = '0;
        v[col] = 1'b1;
        return v;
    endfunction

    // the psum lives in the low half of the popped word
    function automatic glb_data_t lane_steer(input glb_web_t web, input glb_data_t src);
        glb_data_t res;
        res = '0;
        if (web == WEB_LO_HALF) begin
            res = {16'h0000, src[15:0]};
        end else if (web == WEB_HI_HALF) begin
            res = {src[15:0], 16'h0000};
        end else if (web == WEB_FULL) begin
            res = src;
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
        err_cnt++;
    endtask

    task automatic check_port(input string name, input logic exp_write,
                              input logic exp_read, input glb_addr_t exp_addr);
        if (glb_write !== exp_write)
            report_mismatch(name, "glb_write_o", 32'(exp_write), 32'(glb_write));
        if (glb_read !== exp_read)
            report_mismatch(name, "glb_read_o", 32'(exp_read), 32'(glb_read));
        if (glb_addr !== exp_addr)
            report_mismatch(name, "glb_addr_o", exp_addr, glb_addr);
    endtask

    task automatic check_permits(input string name, input logic [PE_COLS-1:0] exp_op,
                                 input logic [PE_COLS-1:0] exp_if,
                                 input logic [PE_COLS-1:0] exp_ip);
        if (permit_opsum !== exp_op)
            report_mismatch(name, "permit_opsum_o", exp_op, permit_opsum);
        if (permit_ifmap !== exp_if)
            report_mismatch(name, "permit_ifmap_o", exp_if, permit_ifmap);
        if (permit_ipsum !== exp_ip)
            report_mismatch(name, "permit_ipsum_o", exp_ip, permit_ipsum);
    endtask

    task automatic init_inputs();
        weight_load_state = 1'b0;
        weight_addr       = '0;
        opsum_write_req   = '0;
        ifmap_read_req    = '0;
        ipsum_read_req    = '0;
        for (int i = 0; i < PE_COLS; i++) begin
            opsum_wr_req[i].addr = $random(seed);
            opsum_wr_req[i].web  = WEB_FULL;
            ifmap_rd_req[i].addr = $random(seed);
            ipsum_rd_req[i].addr = $random(seed);
            opsum_pop_data[i]    = $random(seed);
        end
    endtask

    task automatic reset_idle_state();
        tests_run++;
        @(negedge clk);
        #SETTLE;
        check_port("reset_idle", 1'b0, 1'b0, '0);
        check_permits("reset_idle", '0, '0, '0);
        if (glb_write_web !== '0)
            report_mismatch("reset_idle", "glb_write_web_o", 32'h0, 32'(glb_write_web));
    endtask

    task automatic write_priority();
        glb_data_t exp_data;
        tests_run++;
        @(negedge clk);
        opsum_wr_req[5].web = WEB_HI_HALF;
        opsum_write_req = onehot(5) | onehot(9);
        #SETTLE;
        check_permits("write_priority", onehot(5), '0, '0);
        check_port("write_priority", 1'b0, 1'b0, '0);
        @(negedge clk);
        opsum_write_req = onehot(9);   // column 5 popped and 9 still waits
        #SETTLE;
        check_permits("write_priority", onehot(9), '0, '0);
        check_port("write_priority", 1'b1, 1'b0, opsum_wr_req[5].addr);
        if (glb_write_web !== WEB_HI_HALF)
            report_mismatch("write_priority", "glb_write_web_o", 32'(WEB_HI_HALF),
                            32'(glb_write_web));
        exp_data = lane_steer(WEB_HI_HALF, opsum_pop_data[5]);
        if (glb_write_data !== exp_data)
            report_mismatch("write_priority", "glb_write_data_o", exp_data, glb_write_data);
        @(negedge clk);
        opsum_write_req = '0;
        #SETTLE;
        check_port("write_priority", 1'b1, 1'b0, opsum_wr_req[9].addr);
        exp_data = lane_steer(opsum_wr_req[9].web, opsum_pop_data[9]);
        if (glb_write_data !== exp_data)
            report_mismatch("write_priority", "glb_write_data_o", exp_data, glb_write_data);
        @(negedge clk);
        #SETTLE;
        check_port("write_priority", 1'b0, 1'b0, '0);
    endtask

    task automatic write_lane_steering();
        glb_web_t  masks [4];
        int        col;
        glb_data_t exp_data;
        masks = '{WEB_LO_HALF, WEB_HI_HALF, WEB_FULL, 4'b0110};
        tests_run++;
        for (int m = 0; m < 4; m++) begin
            col = int'({$random(seed)} % PE_COLS);
            @(negedge clk);
            opsum_wr_req[col].web = masks[m];
            opsum_pop_data[col]   = $random(seed);
            opsum_write_req       = onehot(col);
            #SETTLE;
            check_permits("write_lanes", onehot(col), '0, '0);
            @(negedge clk);
            opsum_write_req = '0;
            #SETTLE;
            exp_data = lane_steer(masks[m], opsum_pop_data[col]);
            check_port("write_lanes", 1'b1, 1'b0, opsum_wr_req[col].addr);
            if (glb_write_data !== exp_data)
                report_mismatch("write_lanes", "glb_write_data_o", exp_data, glb_write_data);
        end
        @(negedge clk);   // let the last write retire
    endtask

    task automatic read_priority();
        tests_run++;
        @(negedge clk);
        ifmap_read_req = onehot(7) | onehot(20);
        ipsum_read_req = onehot(3);
        #SETTLE;
        check_permits("read_priority", '0, onehot(7), '0);
        check_port("read_priority", 1'b0, 1'b1, ifmap_rd_req[7].addr);
        @(negedge clk);
        ifmap_read_req = onehot(12) | onehot(30);
        ipsum_read_req = '0;
        #SETTLE;
        check_permits("read_priority", '0, onehot(12), '0);
        check_port("read_priority", 1'b0, 1'b1, ifmap_rd_req[12].addr);
        @(negedge clk);
        ifmap_read_req = '0;   // ipsum only gets a turn now
        ipsum_read_req = onehot(17) | onehot(25);
        #SETTLE;
        check_permits("read_priority", '0, '0, onehot(17));
        check_port("read_priority", 1'b0, 1'b1, ipsum_rd_req[17].addr);
        @(negedge clk);
        ipsum_read_req = '0;
        #SETTLE;
        check_port("read_priority", 1'b0, 1'b0, '0);
    endtask

    task automatic reads_blocked_by_write();
        tests_run++;
        @(negedge clk);
        opsum_write_req = onehot(2);
        ifmap_read_req  = onehot(4);
        #SETTLE;
        check_permits("write_blocks_read", onehot(2), '0, '0);
        check_port("write_blocks_read", 1'b0, 1'b0, '0);
        @(negedge clk);
        opsum_write_req = '0;
        #SETTLE;
        check_permits("write_blocks_read", '0, '0, '0);
        check_port("write_blocks_read", 1'b1, 1'b0, opsum_wr_req[2].addr);
        @(negedge clk);
        #SETTLE;
        check_permits("write_blocks_read", '0, onehot(4), '0);
        check_port("write_blocks_read", 1'b0, 1'b1, ifmap_rd_req[4].addr);
        @(negedge clk);
        ifmap_read_req = '0;
    endtask

    task automatic weight_load_override();
        tests_run++;
        @(negedge clk);
        weight_load_state = 1'b1;
        weight_addr       = $random(seed);
        ifmap_read_req    = onehot(1);
        ipsum_read_req    = onehot(8);
        #SETTLE;
        check_permits("weight_load", '0, '0, '0);
        check_port("weight_load", 1'b0, 1'b1, weight_addr);
        @(negedge clk);
        opsum_write_req = onehot(6);
        #SETTLE;
        check_permits("weight_load", onehot(6), '0, '0);
        check_port("weight_load", 1'b0, 1'b1, weight_addr);
        @(negedge clk);
        opsum_write_req = '0;
        #SETTLE;
        check_port("weight_load", 1'b1, 1'b1, opsum_wr_req[6].addr);   // write owns address
        @(negedge clk);
        weight_load_state = 1'b0;
        ifmap_read_req    = '0;
        ipsum_read_req    = '0;
        #SETTLE;
        check_port("weight_load", 1'b0, 1'b0, '0);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed      = 32'h263ef4f7;
        err_cnt   = 0;
        tests_run = 0;
        init_inputs();
        @(posedge rst_n);
        reset_idle_state();
        write_priority();
        write_lane_steering();
        read_priority();
        reads_blocked_by_write();
        weight_load_override();
        $display("tests run: %0d, errors: %0d", tests_run, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/glb_pkg.sv
hw/pe_array_pkg.sv
hw/req_priority_picker.sv
hw/opsum_write_arbiter.sv
hw/glb_read_arbiter.sv
hw/glb_port_mux.sv
hw/token_arbiter.sv
verif/tb_clk_gen.sv
verif/tb_token_arbiter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the token arbiter testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
    --top-module tb_token_arbiter \
    -f sim.f \
    --Mdir "$BUILD_DIR" \
    -o sim_tb

"./$BUILD_DIR/sim_tb" | tee "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
